// File: Bender.yml
package:
  name: pipe_slice

export_include_dirs:
  - .

sources:
  - core_pkg.sv
  - regfile.sv
  - forward_unit.sv
  - id_stage.sv
  - ex_stage.sv
  - mem_stage.sv
  - pipe_top.sv
  - target: test
    files:
      - tb_pipe_top.sv

// File: core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath widths
`define XLEN     32
`define REG_AW   5
`define IMM_W    16     // immediate field, sign-extended to XLEN

// data memory, word addressed
`define DMEM_AW  6      // 64 words

// forward select codes
// ALU means the EX/MEM result, MEM means the MEM/WB write data
`define FW_NOP   3'd0
`define FW_ALU   3'd1
`define FW_MEM   3'd2

`endif

// File: core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,     // signed
        OP_ADDI,
        OP_LW,
        OP_SW,
        OP_CMP      // equality compare in ID
    } op_t;

    typedef enum logic [2:0] {
        FW_SEL_NOP = `FW_NOP,
        FW_SEL_ALU = `FW_ALU,
        FW_SEL_MEM = `FW_MEM
    } fw_sel_t;

    // ops that end up in the register file
    function automatic logic writes_reg(input op_t op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI, OP_LW};
    endfunction

    // operand forward mux, shared by ID and EX
    function automatic word_t fw_mux(input fw_sel_t sel, input word_t din,
                                     input word_t alu, input word_t mem);
        case (sel)
            FW_SEL_ALU: return alu;
            FW_SEL_MEM: return mem;
            default:    return din;
        endcase
    endfunction

endpackage

// File: ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                ex_valid,
    input  core_pkg::op_t       ex_op,
    input  core_pkg::reg_addr_t ex_dst,
    input  core_pkg::word_t     ex_a,
    input  core_pkg::word_t     ex_b,
    input  core_pkg::word_t     ex_imm,
    input  core_pkg::fw_sel_t   alu_rs_fw,
    input  core_pkg::fw_sel_t   alu_rt_fw,
    input  core_pkg::word_t     fw_mem,
    output logic                mem_valid,
    output core_pkg::op_t       mem_op,
    output core_pkg::reg_addr_t mem_dst,
    output core_pkg::word_t     mem_result,
    output core_pkg::word_t     mem_store_data,
    output logic                alu_we
);

    core_pkg::word_t a;     // forwarded rs
    core_pkg::word_t b;     // forwarded rt, also the store data
    core_pkg::word_t result;

    // ALU-source forward is our own EX/MEM result
    assign a = core_pkg::fw_mux(alu_rs_fw, ex_a, mem_result, fw_mem);
    assign b = core_pkg::fw_mux(alu_rt_fw, ex_b, mem_result, fw_mem);

    always_comb begin
        result = '0;
        case (ex_op)
            core_pkg::OP_ADD: result = a + b;
            core_pkg::OP_SUB: result = a - b;
            core_pkg::OP_AND: result = a & b;
            core_pkg::OP_OR:  result = a | b;
            core_pkg::OP_XOR: result = a ^ b;
            core_pkg::OP_SLT: result[0] = ($signed(a) < $signed(b));
            core_pkg::OP_ADDI,
            core_pkg::OP_LW,
            core_pkg::OP_SW:  result = a + ex_imm;     // sum or byte address
            default:          result = '0;             // compare done in ID
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            mem_op         <= ex_op;
            mem_dst        <= ex_dst;
            mem_result     <= result;
            mem_store_data <= b;
        end
    end

    // a load result is not known yet in EX/MEM
    assign alu_we = mem_valid && core_pkg::writes_reg(mem_op) && (mem_op != core_pkg::OP_LW);

endmodule

// File: forward_unit.sv
`timescale 1ns/100ps

module forward_unit (
    input  core_pkg::reg_addr_t rs,         // ID sources, for the compare
    input  core_pkg::reg_addr_t rt,
    input  core_pkg::reg_addr_t ex_rs,      // ID/EX sources, for the ALU
    input  core_pkg::reg_addr_t ex_rt,
    input  core_pkg::reg_addr_t alu_rn,     // EX/MEM destination
    input  logic                alu_we,
    input  core_pkg::reg_addr_t mem_rn,     // MEM/WB destination
    input  logic                mem_we,
    output core_pkg::fw_sel_t   cmp_rs_fw,
    output core_pkg::fw_sel_t   cmp_rt_fw,
    output core_pkg::fw_sel_t   alu_rs_fw,
    output core_pkg::fw_sel_t   alu_rt_fw
);

    // younger producer wins, so EX/MEM is checked first
    function automatic core_pkg::fw_sel_t pick(
        input core_pkg::reg_addr_t rn,
        input core_pkg::reg_addr_t a_rn,
        input logic                a_we,
        input core_pkg::reg_addr_t m_rn,
        input logic                m_we
    );
        core_pkg::fw_sel_t sel;
        sel = core_pkg::FW_SEL_NOP;
        if (m_we && (m_rn == rn) && (m_rn != '0)) begin
            sel = core_pkg::FW_SEL_MEM;
        end
        if (a_we && (a_rn == rn) && (a_rn != '0)) begin
            sel = core_pkg::FW_SEL_ALU;
        end
        return sel;
    endfunction

    // compare operands in ID
    assign cmp_rs_fw = pick(rs, alu_rn, alu_we, mem_rn, mem_we);
    assign cmp_rt_fw = pick(rt, alu_rn, alu_we, mem_rn, mem_we);

    // ALU operands in EX, also covers the store data
    assign alu_rs_fw = pick(ex_rs, alu_rn, alu_we, mem_rn, mem_we);
    assign alu_rt_fw = pick(ex_rt, alu_rn, alu_we, mem_rn, mem_we);

endmodule

// File: id_stage.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module id_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  core_pkg::op_t       op,
    input  core_pkg::reg_addr_t rs,
    input  core_pkg::reg_addr_t rt,
    input  core_pkg::reg_addr_t rd,
    input  logic [`IMM_W-1:0]   imm,
    input  core_pkg::word_t     rs_data,
    input  core_pkg::word_t     rt_data,
    input  core_pkg::fw_sel_t   cmp_rs_fw,
    input  core_pkg::fw_sel_t   cmp_rt_fw,
    input  core_pkg::word_t     fw_alu,
    input  core_pkg::word_t     fw_mem,
    output logic                ex_valid,
    output core_pkg::op_t       ex_op,
    output core_pkg::reg_addr_t ex_rs,
    output core_pkg::reg_addr_t ex_rt,
    output core_pkg::reg_addr_t ex_dst,
    output core_pkg::word_t     ex_a,
    output core_pkg::word_t     ex_b,
    output core_pkg::word_t     ex_imm,
    output logic                cmp_valid,
    output logic                cmp_eq
);

    core_pkg::word_t     rs_val;    // regfile value after forwarding
    core_pkg::word_t     rt_val;
    core_pkg::reg_addr_t dst;
    core_pkg::word_t     imm_ext;

    assign rs_val = core_pkg::fw_mux(cmp_rs_fw, rs_data, fw_alu, fw_mem);
    assign rt_val = core_pkg::fw_mux(cmp_rt_fw, rt_data, fw_alu, fw_mem);

    assign dst     = (op == core_pkg::OP_LW) ? rt : rd;    // loads target rt
    assign imm_ext = {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid  <= 1'b0;
            cmp_valid <= 1'b0;
        end else begin
            ex_valid  <= in_valid;
            cmp_valid <= in_valid && (op == core_pkg::OP_CMP);
        end
    end

    // ID/EX payload
    // the forwarded values are kept here since a MEM/WB producer is gone by EX
    always_ff @(posedge clk) begin
        if (in_valid) begin
            ex_op  <= op;
            ex_rs  <= rs;
            ex_rt  <= rt;
            ex_dst <= dst;
            ex_a   <= rs_val;
            ex_b   <= rt_val;
            ex_imm <= imm_ext;
        end
        if (in_valid && (op == core_pkg::OP_CMP)) begin
            cmp_eq <= (rs_val == rt_val);
        end
    end

endmodule

// File: mem_stage.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module mem_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                mem_valid,
    input  core_pkg::op_t       mem_op,
    input  core_pkg::reg_addr_t mem_dst,
    input  core_pkg::word_t     mem_result,
    input  core_pkg::word_t     mem_store_data,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data,
    output logic                mem_we
);

    core_pkg::word_t     dmem [0:(1 << `DMEM_AW)-1];
    logic [`DMEM_AW-1:0] addr;
    logic                dmem_we;
    core_pkg::word_t     load_data;
    logic                wb_we;

    assign addr      = mem_result[`DMEM_AW+1:2];   // word address
    assign dmem_we   = mem_valid && (mem_op == core_pkg::OP_SW);
    assign load_data = dmem[addr];

    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[addr] <= mem_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_valid && core_pkg::writes_reg(mem_op);
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        if (mem_valid) begin
            wb_rd   <= mem_dst;
            wb_data <= (mem_op == core_pkg::OP_LW) ? load_data : mem_result;
        end
    end

    assign wb_valid = wb_we;
    assign mem_we   = wb_we;    // also the regfile write enable

endmodule

// File: pipe_testdata.txt
# op rs rt rd imm(hex) expected(hex)
# expected is the write data or the CMP result and is unused for SW, IDLE n adds n empty slots
ADDI  0  0  1 0005 00000005
ADDI  0  0  2 000c 0000000c
ADDI  0  0  3 fffd fffffffd
ADDI  0  0  4 7fff 00007fff
IDLE 3
ADD   1  2  5 0000 00000011
SUB   1  2  6 0000 fffffff9
AND   2  3  7 0000 0000000c
OR    1  2  8 0000 0000000d
XOR   3  4  9 0000 ffff8002
SLT   3  1 10 0000 00000001
SLT   1  3 11 0000 00000000
ADDI  4  0 12 8000 ffffffff
# forwarding between ALU ops
ADD   1  1 13 0000 0000000a
ADD  13  2 14 0000 00000016
SUB  14 13 15 0000 0000000c
ADDI 15  0 13 0001 0000000d
ADDI 13  0 13 0010 0000001d
ADD  13  0 16 0000 0000001d
XOR  16 13 17 0000 00000000
OR   17 15 18 0000 0000000c
ADD  16 18 19 0000 00000029
SLT   6 19 20 0000 00000001
# stores and loads
ADDI  0  0 21 0040 00000040
SW   21 19  0 0004 00000000
ADDI  0  0 22 1234 00001234
SW   21 22  0 0008 00000000
LW   21 23  0 0008 00001234
LW   21 24  0 0004 00000029
IDLE 1
ADD  23 24 25 0000 0000125d
# compares
CMP   1  7  0 0000 0
CMP   2  7  0 0000 1
ADDI  0  0 26 0029 00000029
ADDI  0  0 27 1234 00001234
CMP  26 19  0 0000 1
CMP  27 22  0 0000 1
CMP  26 27  0 0000 0
ADDI  0  0 28 0011 00000011
ADDI  5  0 29 0000 00000011
IDLE 1
CMP  28 29  0 0000 1
CMP  29 13  0 0000 0
CMP  23 22  0 0000 1
# register zero
ADDI  1  0  0 0100 00000105
ADD   0  1 30 0000 00000005
ADD   0  0 31 0000 00000000
CMP   0 11  0 0000 1
XOR   3  4  0 0000 ffff8002
IDLE 1
CMP   0 31  0 0000 1
OR    0  0 30 0000 00000000

// File: pipe_top.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module pipe_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  core_pkg::op_t       op,
    input  core_pkg::reg_addr_t rs,
    input  core_pkg::reg_addr_t rt,
    input  core_pkg::reg_addr_t rd,
    input  logic [`IMM_W-1:0]   imm,
    output logic                cmp_valid,
    output logic                cmp_eq,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data
);

    core_pkg::word_t     rs_data;
    core_pkg::word_t     rt_data;
    core_pkg::fw_sel_t   cmp_rs_fw;
    core_pkg::fw_sel_t   cmp_rt_fw;
    core_pkg::fw_sel_t   alu_rs_fw;
    core_pkg::fw_sel_t   alu_rt_fw;

    // ID/EX
    logic                ex_valid;
    core_pkg::op_t       ex_op;
    core_pkg::reg_addr_t ex_rs;
    core_pkg::reg_addr_t ex_rt;
    core_pkg::reg_addr_t ex_dst;
    core_pkg::word_t     ex_a;
    core_pkg::word_t     ex_b;
    core_pkg::word_t     ex_imm;

    // EX/MEM
    logic                mem_valid;
    core_pkg::op_t       mem_op;
    core_pkg::reg_addr_t mem_dst;
    core_pkg::word_t     mem_result;
    core_pkg::word_t     mem_store_data;
    logic                alu_we;
    logic                mem_we;    // MEM/WB write flag

    regfile u_regfile (
        .clk(clk),
        .rs_addr(rs), .rt_addr(rt),
        .rs_data(rs_data), .rt_data(rt_data),
        .we(mem_we), .wr_addr(wb_rd), .wr_data(wb_data)
    );

    forward_unit u_forward_unit (
        .rs(rs), .rt(rt), .ex_rs(ex_rs), .ex_rt(ex_rt),
        .alu_rn(mem_dst), .alu_we(alu_we),
        .mem_rn(wb_rd), .mem_we(mem_we),
        .cmp_rs_fw(cmp_rs_fw), .cmp_rt_fw(cmp_rt_fw),
        .alu_rs_fw(alu_rs_fw), .alu_rt_fw(alu_rt_fw)
    );

    id_stage u_id_stage (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .op(op), .rs(rs), .rt(rt), .rd(rd), .imm(imm),
        .rs_data(rs_data), .rt_data(rt_data),
        .cmp_rs_fw(cmp_rs_fw), .cmp_rt_fw(cmp_rt_fw),
        .fw_alu(mem_result), .fw_mem(wb_data),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_rs(ex_rs), .ex_rt(ex_rt),
        .ex_dst(ex_dst), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .cmp_valid(cmp_valid), .cmp_eq(cmp_eq)
    );

    ex_stage u_ex_stage (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_dst(ex_dst),
        .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
        .alu_rs_fw(alu_rs_fw), .alu_rt_fw(alu_rt_fw), .fw_mem(wb_data),
        .mem_valid(mem_valid), .mem_op(mem_op), .mem_dst(mem_dst),
        .mem_result(mem_result), .mem_store_data(mem_store_data),
        .alu_we(alu_we)
    );

    mem_stage u_mem_stage (
        .clk(clk), .rst(rst),
        .mem_valid(mem_valid), .mem_op(mem_op), .mem_dst(mem_dst),
        .mem_result(mem_result), .mem_store_data(mem_store_data),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .mem_we(mem_we)
    );

endmodule

// File: regfile.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module regfile (
    input  logic                clk,
    input  core_pkg::reg_addr_t rs_addr,
    input  core_pkg::reg_addr_t rt_addr,
    output core_pkg::word_t     rs_data,
    output core_pkg::word_t     rt_data,
    input  logic                we,
    input  core_pkg::reg_addr_t wr_addr,
    input  core_pkg::word_t     wr_data
);

    core_pkg::word_t regs [0:(1 << `REG_AW)-1];

    // async read, r0 hardwired
    // a same-cycle write is not seen here, MEM/WB forwarding covers it
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;   // r0 writes dropped
        end
    end

endmodule

// File: tb_pipe_top.sv
`timescale 1ns/100ps
`include "core_defines.svh"

module tb_pipe_top;

    localparam int CLK_NS  = 8;
    localparam int RST_CYC = 10;

    logic                clk;
    logic                rst;
    logic                in_valid;
    core_pkg::op_t       op;
    core_pkg::reg_addr_t rs;
    core_pkg::reg_addr_t rt;
    core_pkg::reg_addr_t rd;
    logic [`IMM_W-1:0]   imm;
    logic                cmp_valid;
    logic                cmp_eq;
    logic                wb_valid;
    core_pkg::reg_addr_t wb_rd;
    core_pkg::word_t     wb_data;

    // instruction stream, st_idle is the gap before each instruction
    core_pkg::op_t       st_op[$];
    core_pkg::reg_addr_t st_rs[$];
    core_pkg::reg_addr_t st_rt[$];
    core_pkg::reg_addr_t st_rd[$];
    logic [`IMM_W-1:0]   st_imm[$];
    core_pkg::word_t     st_exp[$];
    int                  st_idle[$];
    int                  total_cycles;
    bit                  loaded;

    // expected results in issue order
    core_pkg::reg_addr_t exp_rd[$];
    core_pkg::word_t     exp_data[$];
    int                  exp_wb_cyc[$];
    logic                exp_eq[$];
    int                  exp_cmp_cyc[$];

    int cyc;
    int wb_errors;
    int cmp_errors;
    int timing_errors;
    int other_errors;

    pipe_top u_dut (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .op(op), .rs(rs), .rt(rt), .rd(rd), .imm(imm),
        .cmp_valid(cmp_valid), .cmp_eq(cmp_eq),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    always #(CLK_NS / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic bit op_from_name(input string name, output core_pkg::op_t code);
        bit ok;
        ok = 1'b1;
        case (name)
            "ADD":   code = core_pkg::OP_ADD;
            "SUB":   code = core_pkg::OP_SUB;
            "AND":   code = core_pkg::OP_AND;
            "OR":    code = core_pkg::OP_OR;
            "XOR":   code = core_pkg::OP_XOR;
            "SLT":   code = core_pkg::OP_SLT;
            "ADDI":  code = core_pkg::OP_ADDI;
            "LW":    code = core_pkg::OP_LW;
            "SW":    code = core_pkg::OP_SW;
            "CMP":   code = core_pkg::OP_CMP;
            default: begin
                code = core_pkg::OP_ADD;
                ok   = 1'b0;
            end
        endcase
        return ok;
    endfunction

    // stores and compares leave nothing in the register file
    function automatic bit writes_register(input core_pkg::op_t code);
        return !(code inside {core_pkg::OP_SW, core_pkg::OP_CMP});
    endfunction

    task automatic load_stream();
        int                fd;
        int                n;
        int                f_rs;
        int                f_rt;
        int                f_rd;
        int                gap;
        string             tok;
        string             rest;
        logic [`IMM_W-1:0] f_imm;
        core_pkg::word_t   f_exp;
        core_pkg::op_t     code;
        gap = 0;
        total_cycles = 0;
        fd = $fopen("pipe_testdata.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open pipe_testdata.txt");
            other_errors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[0] == "#") begin
                    n = $fgets(rest, fd);   // skip comment text
                end else if (tok == "IDLE") begin
                    n = $fscanf(fd, "%d", f_rs);
                    gap += f_rs;
                end else begin
                    n = $fscanf(fd, "%d %d %d %h %h", f_rs, f_rt, f_rd, f_imm, f_exp);
                    if (n != 5 || !op_from_name(tok, code)) begin
                        $display("ERROR: malformed stimulus line starting with %s", tok);
                        other_errors++;
                    end else begin
                        st_op.push_back(code);
                        st_rs.push_back(core_pkg::reg_addr_t'(f_rs));
                        st_rt.push_back(core_pkg::reg_addr_t'(f_rt));
                        st_rd.push_back(core_pkg::reg_addr_t'(f_rd));
                        st_imm.push_back(f_imm);
                        st_exp.push_back(f_exp);
                        st_idle.push_back(gap);
                        total_cycles += gap + 1;
                        gap = 0;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic issue(input int i);
        in_valid <= 1'b1;
        op       <= st_op[i];
        rs       <= st_rs[i];
        rt       <= st_rt[i];
        rd       <= st_rd[i];
        imm      <= st_imm[i];
        // cyc still reads the previous cycle here
        if (writes_register(st_op[i])) begin
            exp_rd.push_back((st_op[i] == core_pkg::OP_LW) ? st_rt[i] : st_rd[i]);
            exp_data.push_back(st_exp[i]);
            exp_wb_cyc.push_back(cyc + 1 + 3);
        end
        if (st_op[i] == core_pkg::OP_CMP) begin
            exp_eq.push_back(st_exp[i][0]);
            exp_cmp_cyc.push_back(cyc + 1 + 1);
        end
    endtask

    task automatic check_wb(input core_pkg::reg_addr_t got_rd, input core_pkg::word_t got_data,
                            input core_pkg::reg_addr_t want_rd, input core_pkg::word_t want_data);
        if (got_rd !== want_rd || got_data !== want_data) begin
            $display("CHECK FAILED @ %0t: write-back r%0d = %h, expected r%0d = %h",
                     $time, got_rd, got_data, want_rd, want_data);
            wb_errors++;
        end
    endtask

    task automatic check_cmp(input logic got, input logic want);
        if (got !== want) begin
            $display("CHECK FAILED @ %0t: cmp_eq = %b, expected %b", $time, got, want);
            cmp_errors++;
        end
    endtask

    task automatic check_latency(input string what, input int got, input int want);
        if (got != want) begin
            $display("CHECK FAILED @ %0t: %s seen in cycle %0d, expected cycle %0d",
                     $time, what, got, want);
            timing_errors++;
        end
    endtask

    // outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst) begin
            if (wb_valid !== 1'b0 || cmp_valid !== 1'b0) begin
                $display("ERROR: wb_valid or cmp_valid not low during reset at %0t", $time);
                other_errors++;
            end
        end else begin
            if (wb_valid === 1'b1) begin
                if (exp_rd.size() == 0) begin
                    $display("ERROR: unexpected write-back to r%0d at %0t", wb_rd, $time);
                    other_errors++;
                end else begin
                    check_wb(wb_rd, wb_data, exp_rd.pop_front(), exp_data.pop_front());
                    check_latency("write-back", cyc, exp_wb_cyc.pop_front());
                end
            end else if (wb_valid !== 1'b0) begin
                $display("ERROR: wb_valid is unknown at %0t", $time);
                other_errors++;
            end
            if (cmp_valid === 1'b1) begin
                if (exp_eq.size() == 0) begin
                    $display("ERROR: unexpected compare result at %0t", $time);
                    other_errors++;
                end else begin
                    check_cmp(cmp_eq, exp_eq.pop_front());
                    check_latency("compare", cyc, exp_cmp_cyc.pop_front());
                end
            end else if (cmp_valid !== 1'b0) begin
                $display("ERROR: cmp_valid is unknown at %0t", $time);
                other_errors++;
            end
        end
    end

    initial begin
        int limit_ns;
        wait (loaded);
        limit_ns = (total_cycles + RST_CYC + 20) * CLK_NS * 4;
        #(limit_ns);
        $display("ERROR: watchdog expired after %0d ns, the run did not finish", limit_ns);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int unsigned seed_value;
        int          drain;
        seed_value = $urandom(32'h982e_8e8a);   // stream itself is fixed
        clk      = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        op       = core_pkg::OP_ADD;
        rs       = '0;
        rt       = '0;
        rd       = '0;
        imm      = '0;
        cyc      = 0;
        load_stream();
        loaded = 1'b1;
        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < st_op.size(); i++) begin
            repeat (st_idle[i]) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            issue(i);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        drain = 0;
        while ((exp_rd.size() != 0 || exp_eq.size() != 0) && drain < 16) begin
            @(posedge clk);
            drain++;
        end
        repeat (4) @(posedge clk);  // room for stray outputs
        if (exp_rd.size() != 0 || exp_eq.size() != 0) begin
            $display("ERROR: %0d write-backs and %0d compares never appeared",
                     exp_rd.size(), exp_eq.size());
            other_errors++;
        end
        $display("errors: write-back %0d, compare %0d, timing %0d, other %0d",
                 wb_errors, cmp_errors, timing_errors, other_errors);
        if (wb_errors + cmp_errors + timing_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
core_pkg.sv
regfile.sv
forward_unit.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
pipe_top.sv
tb_pipe_top.sv
